/* bridge/ahb2apb_bridge.sv */
// AHB to APB bridge, top level
// Single AHB slave port in front of four APB slaves with fixed address
// ranges. One transfer at a time; hready stays low for the APB setup and
// access phases plus any slave wait states. Write data passes straight
// through to pwdata.

`include "bridge_macros.svh"

module ahb2apb_bridge (
  // AHB side
  input  logic                      hclk8,
  input  logic                      hreset_n8,
  input  logic                      hsel,
  input  logic [`BRIDGE_ADDR_W-1:0] haddr,
  input  bridge_pkg::htrans_t       htrans,
  input  logic [`BRIDGE_DATA_W-1:0] hwdata,
  input  logic                      hwrite,
  output logic [`BRIDGE_DATA_W-1:0] hrdata,
  output logic                      hready,

  // APB side
  input  logic [`BRIDGE_NUM_SLAVES-1:0] pready,
  input  logic [`BRIDGE_DATA_W-1:0]     prdata [`BRIDGE_NUM_SLAVES],
  output logic [`BRIDGE_ADDR_W-1:0]     paddr,
  output logic                          penable,
  output logic                          pwrite,
  output logic [`BRIDGE_DATA_W-1:0]     pwdata,
  output logic [`BRIDGE_NUM_SLAVES-1:0] psel
);

  import bridge_pkg::*;

  ahb_xfer_t                 xfer;
  apb_cmd_t                  cmd;
  slave_sel_t                sel;
  logic                      capture;
  logic                      data_phase;
  logic                      done;
  logic                      pready_mux;
  logic [`BRIDGE_DATA_W-1:0] prdata_mux;

  // ------------------------------------------------------------------------
  // AHB front end and address decode
  // ------------------------------------------------------------------------
  ahb_slave_port i_ahb_slave_port (
    .hclk8      (hclk8),
    .hreset_n8  (hreset_n8),
    .hsel       (hsel),
    .htrans     (htrans),
    .haddr      (haddr),
    .hwrite     (hwrite),
    .done       (done),
    .prdata_mux (prdata_mux),
    .hready     (hready),
    .hrdata     (hrdata),
    .capture    (capture),
    .data_phase (data_phase),
    .xfer       (xfer)
  );

  slave_decode i_slave_decode (
    .hclk8     (hclk8),
    .hreset_n8 (hreset_n8),
    .capture   (capture),
    .haddr     (haddr),
    .sel       (sel)
  );

  // ------------------------------------------------------------------------
  // APB sequencer and response mux
  // ------------------------------------------------------------------------
  apb_master_fsm i_apb_master_fsm (
    .hclk8      (hclk8),
    .hreset_n8  (hreset_n8),
    .data_phase (data_phase),
    .xfer       (xfer),
    .sel        (sel),
    .pready_mux (pready_mux),
    .cmd        (cmd),
    .penable    (penable),
    .done       (done)
  );

  apb_read_mux i_apb_read_mux (
    .sel        (cmd.sel),
    .penable    (penable),
    .pready     (pready),
    .prdata     (prdata),
    .pready_mux (pready_mux),
    .prdata_mux (prdata_mux)
  );

  // APB pins straight from the command register
  assign paddr  = cmd.addr;
  assign pwrite = cmd.write;
  assign psel   = cmd.sel;

  // Master holds hwdata while hready is low
  assign pwdata = hwdata;

endmodule

/* bridge/ahb_slave_port.sv */
// AHB slave port of the bridge
// Tracks the address and data phases, captures NONSEQ and SEQ transfers
// while hready is high and stalls the master until the APB side is done.
// Read data is registered into hrdata on completion.

`include "bridge_macros.svh"

module ahb_slave_port (
  input  logic                      hclk8,
  input  logic                      hreset_n8,
  input  logic                      hsel,
  input  bridge_pkg::htrans_t       htrans,
  input  logic [`BRIDGE_ADDR_W-1:0] haddr,
  input  logic                      hwrite,
  input  logic                      done,
  input  logic [`BRIDGE_DATA_W-1:0] prdata_mux,
  output logic                      hready,
  output logic [`BRIDGE_DATA_W-1:0] hrdata,
  output logic                      capture,
  output logic                      data_phase,
  output bridge_pkg::ahb_xfer_t     xfer
);

  import bridge_pkg::*;

  logic addr_phase;
  logic valid_xfer;

  // Only NONSEQ and SEQ start an APB access
  assign valid_xfer = hsel && ((htrans == htrans_nonseq) || (htrans == htrans_seq));
  assign capture    = addr_phase && valid_xfer;
  assign hready     = addr_phase;

  // ------------------------------------------------------------------------
  // Phase tracking
  // ------------------------------------------------------------------------
  always_ff @(posedge hclk8 or negedge hreset_n8) begin
    if (!hreset_n8) begin
      addr_phase <= 1'b1;
      data_phase <= 1'b0;
    end else if (capture) begin
      addr_phase <= 1'b0;
      data_phase <= 1'b1;
    end else if (done) begin
      addr_phase <= 1'b1;
      data_phase <= 1'b0;
    end
  end

  // Address and direction of the accepted transfer
  always_ff @(posedge hclk8 or negedge hreset_n8) begin
    if (!hreset_n8) begin
      xfer <= '0;
    end else if (capture) begin
      xfer.addr  <= haddr;
      xfer.write <= hwrite;
    end
  end

  // Read data back to the master
  always_ff @(posedge hclk8 or negedge hreset_n8) begin
    if (!hreset_n8) begin
      hrdata <= '0;
    end else if (done) begin
      hrdata <= prdata_mux;
    end
  end

  // A completion only ever answers a transfer the port accepted
  a_done_in_data_phase: assert property (@(posedge hclk8) disable iff (!hreset_n8)
    done |-> data_phase)
    else $error("APB completion without a pending AHB transfer");

endmodule

/* bridge/apb_master_fsm.sv */
// APB master sequencer
// Runs one setup and one access phase per captured AHB transfer, holds
// the command steady through slave wait states and flags completion
// back to the AHB port. Always returns to idle after an access.

`include "bridge_macros.svh"

module apb_master_fsm (
  input  logic                   hclk8,
  input  logic                   hreset_n8,
  input  logic                   data_phase,
  input  bridge_pkg::ahb_xfer_t  xfer,
  input  bridge_pkg::slave_sel_t sel,
  input  logic                   pready_mux,
  output bridge_pkg::apb_cmd_t   cmd,
  output logic                   penable,
  output logic                   done
);

  import bridge_pkg::*;

  apb_state_t state;

  // Completion is the access cycle in which the selected slave is ready
  assign done = (state == apb_access) && pready_mux;

  // ------------------------------------------------------------------------
  // State register and APB outputs
  // ------------------------------------------------------------------------
  always_ff @(posedge hclk8 or negedge hreset_n8) begin
    if (!hreset_n8) begin
      state   <= apb_idle;
      cmd     <= '0;
      penable <= 1'b0;
    end else begin
      case (state)
        apb_idle: begin
          // Pending AHB transfer, start the setup phase
          if (data_phase) begin
            state     <= apb_setup;
            cmd.addr  <= xfer.addr;
            cmd.write <= xfer.write;
            cmd.sel   <= sel;
          end
        end

        apb_setup: begin
          state   <= apb_access;
          penable <= 1'b1;
        end

        apb_access: begin
          // Wait states keep everything as is
          if (pready_mux) begin
            state   <= apb_idle;
            penable <= 1'b0;
            cmd.sel <= '0;
          end
        end

        default: begin
          state   <= apb_idle;
          penable <= 1'b0;
          cmd.sel <= '0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------------------

  // penable only while the AHB master is still stalled
  a_penable_pending: assert property (@(posedge hclk8) disable iff (!hreset_n8)
    penable |-> data_phase)
    else $error("penable without a pending AHB transfer");

  // Issued command still matches the captured transfer and select
  a_cmd_matches: assert property (@(posedge hclk8) disable iff (!hreset_n8)
    (state == apb_access) |->
      ((cmd.addr == xfer.addr) && (cmd.write == xfer.write) && (cmd.sel == sel)))
    else $error("APB command differs from the captured transfer");

endmodule

/* bridge/slave_decode.sv */
// APB slave address decoder
// Compares the AHB address against the fixed slave ranges and registers
// a one-hot select together with the transfer capture. Addresses outside
// every range give an all-zero select.

`include "bridge_macros.svh"

module slave_decode (
  input  logic                      hclk8,
  input  logic                      hreset_n8,
  input  logic                      capture,
  input  logic [`BRIDGE_ADDR_W-1:0] haddr,
  output bridge_pkg::slave_sel_t    sel
);

  import bridge_pkg::*;

  // Inclusive range bounds, indexed by slave number
  localparam logic [`BRIDGE_ADDR_W-1:0] range_start [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLAVE0_START,
    `BRIDGE_SLAVE1_START,
    `BRIDGE_SLAVE2_START,
    `BRIDGE_SLAVE3_START
  };
  localparam logic [`BRIDGE_ADDR_W-1:0] range_end [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLAVE0_END,
    `BRIDGE_SLAVE1_END,
    `BRIDGE_SLAVE2_END,
    `BRIDGE_SLAVE3_END
  };

  slave_sel_t hit;

  always_comb begin
    hit = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      hit[i] = (haddr >= range_start[i]) && (haddr <= range_end[i]);
    end
  end

  // Held until the next accepted transfer
  always_ff @(posedge hclk8 or negedge hreset_n8) begin
    if (!hreset_n8) begin
      sel <= '0;
    end else if (capture) begin
      sel <= hit;
    end
  end

  // Overlapping ranges in the map would show up here
  a_sel_onehot: assert property (@(posedge hclk8) disable iff (!hreset_n8)
    $onehot0(sel))
    else $error("more than one slave selected");

endmodule

/* common/bridge_macros.svh */
// AHB-to-APB bridge configuration
// Bus widths, APB slave count and the fixed slave address map

`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Bus widths
`define BRIDGE_ADDR_W      32
`define BRIDGE_DATA_W      32

// Number of APB slaves behind the bridge
`define BRIDGE_NUM_SLAVES  4

// ------------------------------------------------------------------------
// Slave address ranges, inclusive byte addresses
// ------------------------------------------------------------------------
`define BRIDGE_SLAVE0_START 32'h0000_0000
`define BRIDGE_SLAVE0_END   32'h0000_0FFF

`define BRIDGE_SLAVE1_START 32'h0000_1000
`define BRIDGE_SLAVE1_END   32'h0000_1FFF

`define BRIDGE_SLAVE2_START 32'h0000_2000
`define BRIDGE_SLAVE2_END   32'h0000_2FFF

// Hole at 0x3000 to 0x3FFF reads as zero
`define BRIDGE_SLAVE3_START 32'h0000_4000
`define BRIDGE_SLAVE3_END   32'h0000_4FFF

`endif

/* common/bridge_pkg.sv */
// Bridge type package
// AHB transfer kinds, APB sequencer states and the structs that carry
// a captured AHB transfer and the APB command built from it

`include "bridge_macros.svh"

package bridge_pkg;

  // AHB htrans encoding
  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,
    htrans_busy   = 2'b01,
    htrans_nonseq = 2'b10,
    htrans_seq    = 2'b11
  } htrans_t;

  // One-hot APB sequencer state
  typedef enum logic [2:0] {
    apb_idle   = 3'b001,
    apb_setup  = 3'b010,
    apb_access = 3'b100
  } apb_state_t;

  // One bit per APB slave
  typedef logic [`BRIDGE_NUM_SLAVES-1:0] slave_sel_t;

  // Transfer latched in the AHB address phase
  typedef struct packed {
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic                      write;
  } ahb_xfer_t;

  // Command driven onto the APB pins
  typedef struct packed {
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic                      write;
    slave_sel_t                sel;
  } apb_cmd_t;

endpackage

/* files.f */
+incdir+common
common/bridge_pkg.sv
bridge/ahb_slave_port.sv
bridge/slave_decode.sv
bridge/apb_master_fsm.sv
logic/apb_read_mux.sv
bridge/ahb2apb_bridge.sv
tests/apb_slave_model.sv
tests/tb_ahb2apb.sv

/* logic/apb_read_mux.sv */
// APB response multiplexer
// Picks pready and prdata of the selected slave. An access with no slave
// selected completes at once and returns zero.

`include "bridge_macros.svh"

module apb_read_mux (
  input  bridge_pkg::slave_sel_t    sel,
  input  logic                      penable,
  input  bridge_pkg::slave_sel_t    pready,
  input  logic [`BRIDGE_DATA_W-1:0] prdata [`BRIDGE_NUM_SLAVES],
  output logic                      pready_mux,
  output logic [`BRIDGE_DATA_W-1:0] prdata_mux
);

  import bridge_pkg::*;

  slave_sel_t                ready_hit;
  logic [`BRIDGE_DATA_W-1:0] rdata_or;

  // AND-OR mux, unselected slaves are masked to zero
  always_comb begin
    rdata_or = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      if (sel[i]) begin
        rdata_or = rdata_or | prdata[i];
      end
    end
  end

  assign ready_hit = sel & pready;

  // Unmapped address, nobody will answer so the bridge does
  assign pready_mux = (sel == '0) ? penable : |ready_hit;
  assign prdata_mux = rdata_or;

endmodule

/* tests/apb_slave_model.sv */
// Behavioral APB slave for the bridge testbench
// Sixteen words indexed by paddr[5:2], a wait-state count set by the
// testbench, and a record of the last access plus protocol flags

module apb_slave_model #(
  parameter logic [31:0] base = 32'h0
) (
  input  logic        hclk8,
  input  logic        hreset_n8,
  input  logic        psel,
  input  logic        penable,
  input  logic [31:0] paddr,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  input  logic [1:0]  wait_cycles,
  output logic        pready,
  output logic [31:0] prdata,
  output logic [31:0] last_addr,
  output logic [31:0] last_wdata,
  output logic        last_write,
  output logic        seq_ok,
  output logic        proto_err
);

  logic [31:0] mem [16];
  logic [1:0]  wcnt;
  logic        psel_q;

  // Power-up contents depend on the full byte address of each word
  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = {~(base[15:0] + 16'(i * 4)), base[15:0] + 16'(i * 4)};
    end
  end

  assign pready = psel && penable && (wcnt == wait_cycles);
  assign prdata = mem[paddr[5:2]];

  // ------------------------------------------------------------------------
  // Access tracking and protocol flags
  // ------------------------------------------------------------------------
  always @(posedge hclk8 or negedge hreset_n8) begin
    if (!hreset_n8) begin
      wcnt       <= '0;
      psel_q     <= 1'b0;
      last_addr  <= '0;
      last_wdata <= '0;
      last_write <= 1'b0;
      seq_ok     <= 1'b0;
      proto_err  <= 1'b0;
    end else begin
      psel_q <= psel;
      // penable missing in the second psel cycle, or early in the first
      if (psel && psel_q && !penable) begin
        proto_err <= 1'b1;
      end
      if (psel && !psel_q && penable) begin
        proto_err <= 1'b1;
      end
      if (psel && penable) begin
        if (pready) begin
          wcnt       <= '0;
          last_addr  <= paddr;
          last_write <= pwrite;
          last_wdata <= pwdata;
          seq_ok     <= psel_q;
        end else begin
          wcnt <= wcnt + 2'd1;
        end
      end
    end
  end

  // Write port
  always @(posedge hclk8) begin
    if (psel && penable && pready && pwrite) begin
      mem[paddr[5:2]] <= pwdata;
    end
  end

endmodule

/* tests/tb_ahb2apb.sv */
// Testbench for the AHB to APB bridge
// Drives AHB transfers into four APB slave models and checks read data,
// select lines, latency and APB protocol against a shadow memory model

`include "bridge_macros.svh"

module tb_ahb2apb;

  import bridge_pkg::*;

  localparam int timeout_cycles = 50;

  logic        hclk8;
  logic        hreset_n8;
  logic        hsel;
  logic [31:0] haddr;
  htrans_t     htrans;
  logic [31:0] hwdata;
  logic        hwrite;
  logic [31:0] hrdata;
  logic        hready;
  logic [3:0]  pready;
  logic [31:0] prdata [4];
  logic [31:0] paddr;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  psel;
  logic [1:0]  wait_cycles;

  logic [31:0] m_last_addr [4];
  logic [31:0] m_last_wdata [4];
  logic [3:0]  m_last_write;
  logic [3:0]  m_seq_ok;
  logic [3:0]  m_proto_err;

  logic [31:0] shadow [4][16];
  logic [31:0] rng;
  int          errors;
  int          tests_run;
  int          tests_failed;

  ahb2apb_bridge i_ahb2apb_bridge (
    .hclk8     (hclk8),
    .hreset_n8 (hreset_n8),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hrdata    (hrdata),
    .hready    (hready),
    .pready    (pready),
    .prdata    (prdata),
    .paddr     (paddr),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .psel      (psel)
  );

  for (genvar g = 0; g < 4; g++) begin : g_slave
    apb_slave_model #(
      .base ((g == 0) ? `BRIDGE_SLAVE0_START : (g == 1) ? `BRIDGE_SLAVE1_START :
             (g == 2) ? `BRIDGE_SLAVE2_START : `BRIDGE_SLAVE3_START)
    ) i_apb_slave_model (
      .hclk8       (hclk8),
      .hreset_n8   (hreset_n8),
      .psel        (psel[g]),
      .penable     (penable),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .wait_cycles (wait_cycles),
      .pready      (pready[g]),
      .prdata      (prdata[g]),
      .last_addr   (m_last_addr[g]),
      .last_wdata  (m_last_wdata[g]),
      .last_write  (m_last_write[g]),
      .seq_ok      (m_seq_ok[g]),
      .proto_err   (m_proto_err[g])
    );
  end

  initial begin
    hclk8 = 1'b0;
    forever #2 hclk8 = ~hclk8;
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic int slave_of(input logic [31:0] addr);
    if (addr >= `BRIDGE_SLAVE0_START && addr <= `BRIDGE_SLAVE0_END) return 0;
    if (addr >= `BRIDGE_SLAVE1_START && addr <= `BRIDGE_SLAVE1_END) return 1;
    if (addr >= `BRIDGE_SLAVE2_START && addr <= `BRIDGE_SLAVE2_END) return 2;
    if (addr >= `BRIDGE_SLAVE3_START && addr <= `BRIDGE_SLAVE3_END) return 3;
    return -1;
  endfunction

  // Expected read data, unmapped space reads zero
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    int s;
    s = slave_of(addr);
    if (s < 0) return 32'h0;
    return shadow[s][addr[5:2]];
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic init_shadow();
    logic [31:0] b;
    for (int s = 0; s < 4; s++) begin
      b = (s == 0) ? `BRIDGE_SLAVE0_START : (s == 1) ? `BRIDGE_SLAVE1_START :
          (s == 2) ? `BRIDGE_SLAVE2_START : `BRIDGE_SLAVE3_START;
      for (int i = 0; i < 16; i++) begin
        shadow[s][i] = {~(b[15:0] + 16'(i * 4)), b[15:0] + 16'(i * 4)};
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // One AHB transfer with all per-transfer checks
  // ------------------------------------------------------------------------
  task automatic run_xfer(input string name, input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, input logic [1:0] waits);
    int          lat;
    int          s;
    int          t;
    logic [3:0]  sel_seen;
    logic [31:0] exp_rd;

    s = slave_of(addr);
    exp_rd = expected_read(addr);
    t = 0;
    while (!hready && t < timeout_cycles) begin
      @(negedge hclk8);
      t++;
    end
    if (!hready) begin
      $display("%s: bridge never became ready before the transfer", name);
      errors++;
      return;
    end
    hsel        = 1'b1;
    htrans      = htrans_nonseq;
    haddr       = addr;
    hwrite      = write;
    wait_cycles = waits;
    @(negedge hclk8);
    htrans   = htrans_idle;
    hsel     = 1'b0;
    hwdata   = wdata;
    lat      = 0;
    sel_seen = '0;
    while (!hready && lat < timeout_cycles) begin
      sel_seen |= psel;
      lat++;
      @(negedge hclk8);
    end
    if (!hready) begin
      $display("%s: transfer did not complete, hready stayed low", name);
      errors++;
      return;
    end
    check_value({name, " latency"}, (s < 0) ? 3 : 3 + waits, lat);
    check_value({name, " psel"}, (s < 0) ? 4'b0 : 4'(1 << s), sel_seen);
    if (!write) begin
      check_value({name, " hrdata"}, exp_rd, hrdata);
    end
    if (s >= 0) begin
      check_value({name, " paddr"}, addr, m_last_addr[s]);
      check_value({name, " pwrite"}, write, m_last_write[s]);
      check_value({name, " setup before access"}, 1, m_seq_ok[s]);
      if (write) begin
        check_value({name, " pwdata"}, wdata, m_last_wdata[s]);
        shadow[s][addr[5:2]] = wdata;
      end
    end
    check_value({name, " protocol"}, 4'b0, m_proto_err);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
      $display("test %s: fail", name);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    int          e0;
    logic [31:0] a;
    logic [31:0] base [4];

    hreset_n8    = 1'b0;
    hsel         = 1'b0;
    haddr        = '0;
    htrans       = htrans_idle;
    hwdata       = '0;
    hwrite       = 1'b0;
    wait_cycles  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng          = 32'hd55c5c4e;
    base[0] = `BRIDGE_SLAVE0_START;
    base[1] = `BRIDGE_SLAVE1_START;
    base[2] = `BRIDGE_SLAVE2_START;
    base[3] = `BRIDGE_SLAVE3_START;
    init_shadow();
    repeat (3) @(posedge hclk8);
    @(negedge hclk8);
    hreset_n8 = 1'b1;

    // Reset values
    e0 = errors;
    check_value("reset hready", 1, hready);
    check_value("reset psel", 0, psel);
    check_value("reset penable", 0, penable);
    check_value("reset hrdata", 0, hrdata);
    finish_test("reset", e0);

    // Write then read back on every slave
    e0 = errors;
    for (int s = 0; s < 4; s++) begin
      a = base[s] + 32'h8 + 32'(s * 4);
      run_xfer("write", a, 1'b1, 32'hc0de_0000 + 32'(s), 2'd0);
      run_xfer("readback", a, 1'b0, 32'h0, 2'd0);
    end
    finish_test("write_read", e0);

    // Random traffic with random wait states
    e0 = errors;
    for (int n = 0; n < 24; n++) begin
      rng = xorshift32(rng);
      a = base[rng[1:0]] + {26'h0, rng[7:4], 2'b00};
      run_xfer("random", a, rng[2], xorshift32(rng ^ 32'h1234_5678), rng[9:8]);
    end
    finish_test("random_waits", e0);

    // Unmapped hole
    e0 = errors;
    run_xfer("unmapped low", 32'h0000_3000, 1'b0, 32'h0, 2'd2);
    run_xfer("unmapped high", 32'h0000_3ffc, 1'b0, 32'h0, 2'd1);
    finish_test("unmapped", e0);

    // IDLE, BUSY and deselected transfers are ignored
    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      hsel   = (k != 2);
      htrans = (k == 0) ? htrans_idle : (k == 1) ? htrans_busy : htrans_nonseq;
      haddr  = base[k] + 32'h4;
      hwrite = 1'b1;
      hwdata = 32'hdead_beef;
      repeat (2) begin
        @(negedge hclk8);
        check_value("ignored hready", 1, hready);
        check_value("ignored psel", 0, psel);
      end
      hsel   = 1'b0;
      htrans = htrans_idle;
    end
    for (int k = 0; k < 3; k++) begin
      run_xfer("unchanged", base[k] + 32'h4, 1'b0, 32'h0, 2'd0);
    end
    finish_test("ignored", e0);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
